// File: hw/rayint_pkg.sv
`default_nettype none

package rayint_pkg;

  // Vertex and ray coordinate.
  typedef logic signed [15:0] coord_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
    coord_t z;
  } vec3_t;

  // Difference of two coordinates.
  typedef logic signed [16:0] edge_t;

  typedef struct packed {
    edge_t x;
    edge_t y;
    edge_t z;
  } edge3_t;

  // Products of edges and directions, also the normal.
  typedef logic signed [35:0] cross_t;

  typedef struct packed {
    cross_t x;
    cross_t y;
    cross_t z;
  } cross3_t;

  typedef logic signed [55:0] dot_t;

  // Zero marks the end of the triangle list.
  typedef logic [31:0] sid_t;

  typedef struct packed {
    vec3_t v0;
    vec3_t v1;
    vec3_t v2;
    sid_t  sid;
  } tri_t;

  typedef struct packed {
    vec3_t orig;
    vec3_t dir;
  } ray_t;

  typedef struct packed {
    logic    valid;
    logic    last;
    logic    hit;
    sid_t    sid;
    dot_t    t_num;
    dot_t    t_den;
    cross3_t normal;
  } hit_t;

endpackage

`default_nettype wire

// File: hw/ray_control.sv
`timescale 1ns/10ps
`default_nettype none

module ray_control #(
  parameter int NUM_THREAD = 32
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          start,
  input  logic [$clog2(NUM_THREAD)-1:0] thread_id_in,
  input  rayint_pkg::ray_t              ray_in,
  input  logic                          sel_done,
  output logic                          busy,
  output logic                          begin_fetch,
  output logic                          clear_best,
  output rayint_pkg::ray_t              ray,
  output logic [$clog2(NUM_THREAD)-1:0] thread_id_out,
  output logic                          done
);

  typedef enum logic {IDLE, RUN} state_t;

  state_t state;
  logic   accept;

  // A start is only taken while idle.
  assign accept      = start && (state == IDLE);
  assign begin_fetch = accept;
  assign clear_best  = accept;
  assign busy        = (state == RUN);
  assign done        = sel_done && (state == RUN);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: if (start) state <= RUN;
        RUN:  if (sel_done) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Ray stays fixed for the whole triangle sweep.
  always_ff @(posedge clk) begin
    if (accept) begin
      ray           <= ray_in;
      thread_id_out <= thread_id_in;
    end
  end

  // A finished sweep always belongs to an accepted ray.
  a_done_in_run: assert property (@(posedge clk) disable iff (rst)
    sel_done |-> (state == RUN));

endmodule

`default_nettype wire

// File: hw/tri_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module tri_fetch #(
  parameter int NUM_TRIANGLE = 512
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            begin_fetch,
  input  logic                            mem_rdy,
  input  rayint_pkg::tri_t                mem_tri,
  output logic                            mem_en,
  output logic [$clog2(NUM_TRIANGLE)-1:0] tri_addr,
  output logic                            tri_valid,
  output logic                            tri_last,
  output rayint_pkg::tri_t                tri_data
);

  localparam int ADDR_W = $clog2(NUM_TRIANGLE);

  logic wait_rdy;
  logic end_of_list;

  // Sentinel entry or final table slot.
  assign end_of_list = (mem_tri.sid == '0) || (tri_addr == ADDR_W'(NUM_TRIANGLE - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tri_addr  <= '0;
      mem_en    <= 1'b0;
      tri_valid <= 1'b0;
      tri_last  <= 1'b0;
    end else begin
      mem_en    <= 1'b0;
      tri_valid <= 1'b0;
      tri_last  <= 1'b0;
      if (begin_fetch) begin
        tri_addr <= '0;
        mem_en   <= 1'b1;
      end else if (mem_rdy && wait_rdy) begin
        tri_valid <= 1'b1;
        tri_last  <= end_of_list;
        if (!end_of_list) begin
          tri_addr <= tri_addr + 1'b1;
          mem_en   <= 1'b1;
        end
      end
    end
  end

  // Request in flight.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wait_rdy <= 1'b0;
    end else if (mem_en) begin
      wait_rdy <= 1'b1;
    end else if (mem_rdy) begin
      wait_rdy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_rdy) begin
      tri_data <= mem_tri;
    end
  end

  a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
    mem_en |-> !wait_rdy);

endmodule

`default_nettype wire

// File: hw/tri_intersect.sv
`timescale 1ns/10ps
`default_nettype none

module tri_intersect (
  input  logic             clk,
  input  logic             rst,
  input  rayint_pkg::ray_t ray,
  input  logic             tri_valid,
  input  logic             tri_last,
  input  rayint_pkg::tri_t tri_data,
  output rayint_pkg::hit_t hit_out
);

  function automatic rayint_pkg::cross3_t cross3(
    input rayint_pkg::dot_t ax, ay, az, bx, by, bz
  );
    rayint_pkg::cross3_t r;
    r.x = rayint_pkg::cross_t'(ay * bz - az * by);
    r.y = rayint_pkg::cross_t'(az * bx - ax * bz);
    r.z = rayint_pkg::cross_t'(ax * by - ay * bx);
    return r;
  endfunction

  function automatic rayint_pkg::dot_t dot3(
    input rayint_pkg::dot_t ax, ay, az, bx, by, bz
  );
    return ax * bx + ay * by + az * bz;
  endfunction

  rayint_pkg::edge3_t  e1, e2, s;
  rayint_pkg::cross3_t p;
  rayint_pkg::edge3_t  s1_e1, s1_e2, s1_s;
  rayint_pkg::cross3_t s1_p;
  rayint_pkg::sid_t    s1_sid;
  logic                s1_valid, s1_last;

  rayint_pkg::dot_t    det, u;
  rayint_pkg::cross3_t q, n;
  rayint_pkg::dot_t    s2_det, s2_u;
  rayint_pkg::cross3_t s2_q, s2_n;
  rayint_pkg::edge3_t  s2_e2;
  rayint_pkg::sid_t    s2_sid;
  logic                s2_valid, s2_last;

  rayint_pkg::dot_t    v, tn, det_f, u_f, v_f, tn_f;
  logic                neg, hit_now;
  rayint_pkg::dot_t    s3_tn, s3_det;
  rayint_pkg::cross3_t s3_n;
  rayint_pkg::sid_t    s3_sid;
  logic                s3_valid, s3_last, s3_hit;

  // Stage 1. Edges from v0 and p = dir x e2.
  always_comb begin
    e1.x = tri_data.v1.x - tri_data.v0.x;
    e1.y = tri_data.v1.y - tri_data.v0.y;
    e1.z = tri_data.v1.z - tri_data.v0.z;
    e2.x = tri_data.v2.x - tri_data.v0.x;
    e2.y = tri_data.v2.y - tri_data.v0.y;
    e2.z = tri_data.v2.z - tri_data.v0.z;
    s.x  = ray.orig.x - tri_data.v0.x;
    s.y  = ray.orig.y - tri_data.v0.y;
    s.z  = ray.orig.z - tri_data.v0.z;
    p    = cross3(ray.dir.x, ray.dir.y, ray.dir.z, e2.x, e2.y, e2.z);
  end

  // Stage 2. Determinant, u, q and the normal.
  assign det = dot3(s1_e1.x, s1_e1.y, s1_e1.z, s1_p.x, s1_p.y, s1_p.z);
  assign u   = dot3(s1_s.x, s1_s.y, s1_s.z, s1_p.x, s1_p.y, s1_p.z);
  assign q   = cross3(s1_s.x, s1_s.y, s1_s.z, s1_e1.x, s1_e1.y, s1_e1.z);
  assign n   = cross3(s1_e1.x, s1_e1.y, s1_e1.z, s1_e2.x, s1_e2.y, s1_e2.z);

  // Stage 3. Fold the sign of det into all terms, then test.
  always_comb begin
    v     = dot3(ray.dir.x, ray.dir.y, ray.dir.z, s2_q.x, s2_q.y, s2_q.z);
    tn    = dot3(s2_e2.x, s2_e2.y, s2_e2.z, s2_q.x, s2_q.y, s2_q.z);
    neg   = (s2_det < 0);
    det_f = neg ? -s2_det : s2_det;
    u_f   = neg ? -s2_u : s2_u;
    v_f   = neg ? -v : v;
    tn_f  = neg ? -tn : tn;
    hit_now = s2_valid && (det_f != '0) && (u_f >= 0) && (v_f >= 0) &&
              (u_f + v_f <= det_f) && (tn_f > 0);
  end

  // Sentinel entries travel as last but never as valid.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
      s2_valid <= 1'b0;
      s2_last  <= 1'b0;
      s3_valid <= 1'b0;
      s3_last  <= 1'b0;
      s3_hit   <= 1'b0;
    end else begin
      s1_valid <= tri_valid && (tri_data.sid != '0);
      s1_last  <= tri_valid && tri_last;
      s2_valid <= s1_valid;
      s2_last  <= s1_last;
      s3_valid <= s2_valid;
      s3_last  <= s2_last;
      s3_hit   <= hit_now;
    end
  end

  always_ff @(posedge clk) begin
    s1_e1  <= e1;
    s1_e2  <= e2;
    s1_s   <= s;
    s1_p   <= p;
    s1_sid <= tri_data.sid;
    s2_det <= det;
    s2_u   <= u;
    s2_q   <= q;
    s2_n   <= n;
    s2_e2  <= s1_e2;
    s2_sid <= s1_sid;
    s3_tn  <= tn_f;
    s3_det <= det_f;
    s3_n   <= s2_n;
    s3_sid <= s2_sid;
  end

  always_comb begin
    hit_out.valid  = s3_valid;
    hit_out.last   = s3_last;
    hit_out.hit    = s3_hit;
    hit_out.sid    = s3_sid;
    hit_out.t_num  = s3_tn;
    hit_out.t_den  = s3_det;
    hit_out.normal = s3_n;
  end

endmodule

`default_nettype wire

// File: hw/hit_select.sv
`timescale 1ns/10ps
`default_nettype none

module hit_select (
  input  logic                clk,
  input  logic                rst,
  input  logic                clear_best,
  input  rayint_pkg::hit_t    hit_in,
  output logic                sel_done,
  output rayint_pkg::sid_t    best_sid,
  output rayint_pkg::dot_t    best_t_num,
  output rayint_pkg::dot_t    best_t_den,
  output rayint_pkg::cross3_t best_normal
);

  logic                                         best_hit;
  logic signed [2*$bits(rayint_pkg::dot_t)-1:0] lhs, rhs;
  logic                                         take;

  // Compare tn/det without division, both denominators are positive.
  assign lhs = hit_in.t_num * best_t_den;
  assign rhs = best_t_num * hit_in.t_den;

  // Strict less so a tie keeps the earlier triangle.
  assign take = hit_in.valid && hit_in.hit && (!best_hit || (lhs < rhs));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sel_done    <= 1'b0;
      best_hit    <= 1'b0;
      best_sid    <= '0;
      best_t_num  <= '0;
      best_t_den  <= '0;
      best_normal <= '0;
    end else begin
      sel_done <= hit_in.last;
      if (clear_best) begin
        best_hit    <= 1'b0;
        best_sid    <= '0;
        best_t_num  <= '0;
        best_t_den  <= '0;
        best_normal <= '0;
      end else if (take) begin
        best_hit    <= 1'b1;
        best_sid    <= hit_in.sid;
        best_t_num  <= hit_in.t_num;
        best_t_den  <= hit_in.t_den;
        best_normal <= hit_in.normal;
      end
    end
  end

  // Sign folding upstream keeps every stored distance well formed.
  a_den_positive: assert property (@(posedge clk) disable iff (rst)
    best_hit |-> (best_t_den > 0));

endmodule

`default_nettype wire

// File: hw/rayint_top.sv
`timescale 1ns/10ps
`default_nettype none

module rayint_top #(
  parameter int NUM_THREAD   = 32,
  parameter int NUM_TRIANGLE = 512
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            start,
  input  logic [$clog2(NUM_THREAD)-1:0]   thread_id_in,
  input  rayint_pkg::ray_t                ray_in,
  input  logic                            mem_rdy,
  input  rayint_pkg::tri_t                mem_tri,
  output logic                            busy,
  output logic                            mem_en,
  output logic [$clog2(NUM_TRIANGLE)-1:0] tri_addr,
  output logic                            done,
  output logic [$clog2(NUM_THREAD)-1:0]   thread_id_out,
  output rayint_pkg::sid_t                best_sid,
  output rayint_pkg::dot_t                best_t_num,
  output rayint_pkg::dot_t                best_t_den,
  output rayint_pkg::cross3_t             best_normal
);

  logic             begin_fetch;
  logic             clear_best;
  logic             sel_done;
  logic             tri_valid;
  logic             tri_last;
  rayint_pkg::ray_t ray;
  rayint_pkg::tri_t tri_data;
  rayint_pkg::hit_t hit;

  ray_control #(
    .NUM_THREAD (NUM_THREAD)
  ) u_control (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .thread_id_in  (thread_id_in),
    .ray_in        (ray_in),
    .sel_done      (sel_done),
    .busy          (busy),
    .begin_fetch   (begin_fetch),
    .clear_best    (clear_best),
    .ray           (ray),
    .thread_id_out (thread_id_out),
    .done          (done)
  );

  tri_fetch #(
    .NUM_TRIANGLE (NUM_TRIANGLE)
  ) u_fetch (
    .clk         (clk),
    .rst         (rst),
    .begin_fetch (begin_fetch),
    .mem_rdy     (mem_rdy),
    .mem_tri     (mem_tri),
    .mem_en      (mem_en),
    .tri_addr    (tri_addr),
    .tri_valid   (tri_valid),
    .tri_last    (tri_last),
    .tri_data    (tri_data)
  );

  tri_intersect u_intersect (
    .clk       (clk),
    .rst       (rst),
    .ray       (ray),
    .tri_valid (tri_valid),
    .tri_last  (tri_last),
    .tri_data  (tri_data),
    .hit_out   (hit)
  );

  hit_select u_select (
    .clk         (clk),
    .rst         (rst),
    .clear_best  (clear_best),
    .hit_in      (hit),
    .sel_done    (sel_done),
    .best_sid    (best_sid),
    .best_t_num  (best_t_num),
    .best_t_den  (best_t_den),
    .best_normal (best_normal)
  );

endmodule

`default_nettype wire

// File: bench/rayint_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rayint_tb;

  localparam int NUM_THREAD   = 32;
  localparam int NUM_TRIANGLE = 512;
  localparam int TID_W        = $clog2(NUM_THREAD);
  localparam int ADDR_W       = $clog2(NUM_TRIANGLE);
  // Full table sweep costs up to 5 cycles per entry and random runs about 60 each.
  localparam int MAX_CYCLES   = 20000;

  logic                      clk = 1'b0;
  logic                      rst;
  logic                      start;
  logic [TID_W-1:0]          thread_id_in;
  rayint_pkg::ray_t          ray_in;
  logic                      mem_rdy;
  rayint_pkg::tri_t          mem_tri;
  logic                      busy;
  logic                      mem_en;
  logic [ADDR_W-1:0]         tri_addr;
  logic                      done;
  logic [TID_W-1:0]          thread_id_out;
  rayint_pkg::sid_t          best_sid;
  rayint_pkg::dot_t          best_t_num;
  rayint_pkg::dot_t          best_t_den;
  rayint_pkg::cross3_t       best_normal;

  rayint_pkg::tri_t          tri_mem [0:NUM_TRIANGLE-1];

  integer                    seed = 32'he0708794;
  int                        errors = 0;
  int                        cycle = 0;
  int                        last_rdy_cyc = 0;
  int                        req_count = 0;
  int                        wait_cnt = 0;
  logic                      pend = 1'b0;
  logic [ADDR_W-1:0]         req_addr;

  rayint_top #(
    .NUM_THREAD   (NUM_THREAD),
    .NUM_TRIANGLE (NUM_TRIANGLE)
  ) uut (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .thread_id_in  (thread_id_in),
    .ray_in        (ray_in),
    .mem_rdy       (mem_rdy),
    .mem_tri       (mem_tri),
    .busy          (busy),
    .mem_en        (mem_en),
    .tri_addr      (tri_addr),
    .done          (done),
    .thread_id_out (thread_id_out),
    .best_sid      (best_sid),
    .best_t_num    (best_t_num),
    .best_t_den    (best_t_den),
    .best_normal   (best_normal)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles without finishing", cycle);
      $display("Test FAILED");
      $finish;
    end
  end

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // Triangle memory. One request at a time is answered 1 to 4 cycles later.
  always @(negedge clk) begin
    mem_rdy = 1'b0;
    if (pend) begin
      wait_cnt = wait_cnt - 1;
      if (wait_cnt == 0) begin
        mem_rdy      = 1'b1;
        mem_tri      = tri_mem[req_addr];
        pend         = 1'b0;
        last_rdy_cyc = cycle;
      end
    end
    if (mem_en) begin
      if (pend) begin
        errors++;
        $display("Memory request issued while another one was outstanding");
      end
      pend      = 1'b1;
      req_addr  = tri_addr;
      wait_cnt  = rand_range(1, 4);
      req_count = req_count + 1;
    end
  end

  function automatic rayint_pkg::vec3_t vec(input int x, input int y, input int z);
    rayint_pkg::vec3_t r;
    r.x = rayint_pkg::coord_t'(x);
    r.y = rayint_pkg::coord_t'(y);
    r.z = rayint_pkg::coord_t'(z);
    return r;
  endfunction

  function automatic rayint_pkg::tri_t mk_tri(input rayint_pkg::vec3_t a, input rayint_pkg::vec3_t b,
                                               input rayint_pkg::vec3_t c, input rayint_pkg::sid_t sid);
    rayint_pkg::tri_t t;
    t.v0  = a;
    t.v1  = b;
    t.v2  = c;
    t.sid = sid;
    return t;
  endfunction

  // Moller-Trumbore without division in 64-bit integers.
  function automatic rayint_pkg::hit_t ref_intersect(input rayint_pkg::tri_t t,
                                                      input rayint_pkg::ray_t r);
    longint e1x, e1y, e1z, e2x, e2y, e2z, sx, sy, sz;
    longint dx, dy, dz, px, py, pz, qx, qy, qz;
    longint det, uu, vv, tn;
    rayint_pkg::hit_t h;
    e1x = longint'(t.v1.x) - longint'(t.v0.x);
    e1y = longint'(t.v1.y) - longint'(t.v0.y);
    e1z = longint'(t.v1.z) - longint'(t.v0.z);
    e2x = longint'(t.v2.x) - longint'(t.v0.x);
    e2y = longint'(t.v2.y) - longint'(t.v0.y);
    e2z = longint'(t.v2.z) - longint'(t.v0.z);
    sx  = longint'(r.orig.x) - longint'(t.v0.x);
    sy  = longint'(r.orig.y) - longint'(t.v0.y);
    sz  = longint'(r.orig.z) - longint'(t.v0.z);
    dx  = longint'(r.dir.x);
    dy  = longint'(r.dir.y);
    dz  = longint'(r.dir.z);
    px  = dy * e2z - dz * e2y;
    py  = dz * e2x - dx * e2z;
    pz  = dx * e2y - dy * e2x;
    det = e1x * px + e1y * py + e1z * pz;
    uu  = sx * px + sy * py + sz * pz;
    qx  = sy * e1z - sz * e1y;
    qy  = sz * e1x - sx * e1z;
    qz  = sx * e1y - sy * e1x;
    vv  = dx * qx + dy * qy + dz * qz;
    tn  = e2x * qx + e2y * qy + e2z * qz;
    if (det < 0) begin
      det = -det;
      uu  = -uu;
      vv  = -vv;
      tn  = -tn;
    end
    h          = '0;
    h.valid    = 1'b1;
    h.hit      = (det != 0) && (uu >= 0) && (vv >= 0) && (uu + vv <= det) && (tn > 0);
    h.sid      = t.sid;
    h.t_num    = rayint_pkg::dot_t'(tn);
    h.t_den    = rayint_pkg::dot_t'(det);
    h.normal.x = rayint_pkg::cross_t'(e1y * e2z - e1z * e2y);
    h.normal.y = rayint_pkg::cross_t'(e1z * e2x - e1x * e2z);
    h.normal.z = rayint_pkg::cross_t'(e1x * e2y - e1y * e2x);
    return h;
  endfunction

  // Walk the table up to the sentinel or the final address.
  function automatic rayint_pkg::hit_t ref_best(input rayint_pkg::ray_t r);
    rayint_pkg::hit_t best;
    rayint_pkg::hit_t h;
    bit               stop;
    best = '0;
    stop = 1'b0;
    for (int a = 0; a < NUM_TRIANGLE && !stop; a++) begin
      if (tri_mem[a].sid == '0) begin
        stop = 1'b1;
      end else begin
        h = ref_intersect(tri_mem[a], r);
        if (h.hit && (!best.hit || longint'(h.t_num) * longint'(best.t_den) <
                                   longint'(best.t_num) * longint'(h.t_den))) begin
          best = h;
        end
      end
    end
    return best;
  endfunction

  task automatic clear_table();
    for (int a = 0; a < NUM_TRIANGLE; a++) begin
      tri_mem[a] = '0;
    end
  endtask

  task automatic check_field(input string name, input logic [111:0] got,
                             input logic [111:0] exp);
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  // Start one ray, optionally retrigger while busy, and check the result at done.
  task automatic run_ray(input logic [TID_W-1:0] tid, input rayint_pkg::ray_t r, input bit poke);
    rayint_pkg::hit_t exp;
    exp = ref_best(r);
    @(negedge clk);
    start        = 1'b1;
    thread_id_in = tid;
    ray_in       = r;
    @(negedge clk);
    start = 1'b0;
    if (poke) begin
      check_field("busy", busy, 1'b1);
      start        = 1'b1;
      thread_id_in = ~tid;
      ray_in       = rayint_pkg::ray_t'(~r);
      @(negedge clk);
      start = 1'b0;
    end
    while (!done) @(negedge clk);
    if (cycle - last_rdy_cyc != 5) begin
      errors++;
      $display("done arrived %0d cycles after the last memory response instead of 5",
               cycle - last_rdy_cyc);
    end
    check_field("thread_id_out", thread_id_out, tid);
    check_field("best_sid", best_sid, exp.sid);
    check_field("best_t_num", best_t_num, exp.t_num);
    check_field("best_t_den", best_t_den, exp.t_den);
    check_field("best_normal", best_normal, exp.normal);
  endtask

  task automatic test_single_hit();
    rayint_pkg::ray_t r;
    clear_table();
    tri_mem[0] = mk_tri(vec(-20, -20, 40), vec(30, -20, 40), vec(-20, 30, 40), 32'h11);
    r.orig = vec(2, 3, -5);
    r.dir  = vec(0, 0, 3);
    run_ray(5'd3, r, 1'b0);
    check_field("best_sid", best_sid, 32'h11);
  endtask

  task automatic test_misses();
    rayint_pkg::ray_t r;
    rayint_pkg::tri_t miss [0:2];
    // Parallel to the ray, outside the edges, behind the origin.
    miss[0] = mk_tri(vec(0, -10, 10), vec(0, 10, 10), vec(0, 0, 30), 32'h21);
    miss[1] = mk_tri(vec(40, 40, 20), vec(60, 40, 20), vec(50, 60, 20), 32'h22);
    miss[2] = mk_tri(vec(-10, -10, -20), vec(10, -10, -20), vec(0, 10, -20), 32'h23);
    r.orig = vec(0, 0, 0);
    r.dir  = vec(0, 0, 1);
    for (int k = 0; k < 3; k++) begin
      clear_table();
      tri_mem[0] = miss[k];
      run_ray(TID_W'(k + 7), r, 1'b0);
      check_field("best_sid", best_sid, '0);
      check_field("best_t_num", best_t_num, '0);
      check_field("best_t_den", best_t_den, '0);
      check_field("best_normal", best_normal, '0);
    end
  endtask

  task automatic test_closest();
    int               zs [0:7] = '{50, 30, 40, 20, 60, 20, 35, 25};
    int               sz [0:7] = '{10, 20, 10, 10, 30, 25, 15, 10};
    bit               wd [0:7] = '{0, 1, 0, 1, 0, 0, 1, 0};
    rayint_pkg::ray_t r;
    clear_table();
    for (int i = 0; i < 8; i++) begin
      if (wd[i]) begin
        tri_mem[i] = mk_tri(vec(-sz[i], -sz[i], zs[i]), vec(0, sz[i], zs[i]),
                            vec(sz[i], -sz[i], zs[i]), 32'(i + 1));
      end else begin
        tri_mem[i] = mk_tri(vec(-sz[i], -sz[i], zs[i]), vec(sz[i], -sz[i], zs[i]),
                            vec(0, sz[i], zs[i]), 32'(i + 1));
      end
    end
    r.orig = vec(1, 2, 0);
    r.dir  = vec(0, 0, 2);
    run_ray(5'd12, r, 1'b0);
    // Entries 4 and 6 share the nearest depth.
    check_field("best_sid", best_sid, 32'd4);
  endtask

  task automatic test_last_address();
    rayint_pkg::ray_t r;
    int               x;
    int               z;
    for (int a = 0; a < NUM_TRIANGLE; a++) begin
      x = a - 256;
      z = 100 + a % 37;
      tri_mem[a] = mk_tri(vec(x - 2, -2, z), vec(x + 2, -2, z), vec(x, 3, z), 32'(a + 1));
    end
    tri_mem[NUM_TRIANGLE-1] = mk_tri(vec(-50, -50, 10), vec(50, -50, 10), vec(0, 50, 10),
                                     32'(NUM_TRIANGLE));
    r.orig    = vec(0, 0, 0);
    r.dir     = vec(0, 0, 1);
    req_count = 0;
    run_ray(5'd21, r, 1'b0);
    check_field("best_sid", best_sid, 32'(NUM_TRIANGLE));
    if (req_count != NUM_TRIANGLE) begin
      errors++;
      $display("Fetched %0d triangles, the whole table has %0d", req_count, NUM_TRIANGLE);
    end
  endtask

  task automatic test_random();
    int               n;
    logic [TID_W-1:0] tid;
    rayint_pkg::ray_t r;
    for (int run = 0; run < 50; run++) begin
      clear_table();
      n = rand_range(1, 12);
      for (int i = 0; i < n; i++) begin
        tri_mem[i] = mk_tri(vec(rand_range(-80, 80), rand_range(-80, 80), rand_range(0, 200)),
                            vec(rand_range(-80, 80), rand_range(-80, 80), rand_range(0, 200)),
                            vec(rand_range(-80, 80), rand_range(-80, 80), rand_range(0, 200)),
                            32'(run * 16 + i + 1));
      end
      r.orig = vec(rand_range(-50, 50), rand_range(-50, 50), rand_range(-100, -40));
      r.dir  = vec(rand_range(-20, 20), rand_range(-20, 20), rand_range(5, 60));
      tid    = TID_W'(rand_range(0, NUM_THREAD - 1));
      run_ray(tid, r, 1'b1);
    end
  endtask

  initial begin
    rst          = 1'b1;
    start        = 1'b0;
    thread_id_in = '0;
    ray_in       = '0;
    mem_rdy      = 1'b0;
    mem_tri      = '0;
    clear_table();
    repeat (8) @(negedge clk);
    rst = 1'b0;
    check_field("busy", busy, 1'b0);
    check_field("mem_en", mem_en, 1'b0);
    check_field("done", done, 1'b0);

    test_single_hit();
    test_misses();
    test_closest();
    test_last_address();
    test_random();

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rayint.f
hw/rayint_pkg.sv
hw/ray_control.sv
hw/tri_fetch.sv
hw/tri_intersect.sv
hw/hit_select.sv
hw/rayint_top.sv
bench/rayint_tb.sv
